/* include/trace_defines.svh */
`ifndef TRACE_DEFINES_SVH
`define TRACE_DEFINES_SVH

// legal pc window, both ends inclusive
`define TRACE_PC_MIN 32'h0000_3000
`define TRACE_PC_MAX 32'h0000_4fff

// memory writes must stay below the code region
`define TRACE_ADDR_MAX 32'h0000_2fff

// highest register number in the register file
`define TRACE_GRF_MAX 16'd31

// most digits in time and grf
`define TRACE_DEC_DIGITS 4'd4

// exact digit count of pc, addr and data
`define TRACE_HEX_DIGITS 4'd8

`endif

/* rtl/trace_pkg.sv */
package trace_pkg;

    // one ascii character per clock
    typedef logic [7:0] char_t;

    // line syntax states
    typedef enum logic [4:0] {
        st_idle,
        st_caret,
        st_time,
        st_at,
        st_pc,
        st_colon,
        st_grf_mark,
        st_grf,
        st_grf_space,
        st_lt,
        st_eq,
        st_data,
        st_mem_mark,
        st_addr,
        st_addr_space,
        st_addr_lt,
        st_addr_eq,
        st_addr_data,
        st_done
    } parse_state_e;

    // what the field store does with the current char
    typedef enum logic [2:0] {
        op_none,
        op_clear,
        op_time_digit,
        op_pc_digit,
        op_grf_digit,
        op_addr_digit
    } field_op_e;

    typedef enum logic [1:0] {
        fmt_none      = 2'd0,
        fmt_reg_write = 2'd1,
        fmt_mem_write = 2'd2
    } format_e;

    typedef struct packed {
        logic [15:0] time_val;
        logic [31:0] pc;
        logic [15:0] grf;
        logic [31:0] addr;
    } line_fields_t;

    // time_bad lands in bit 0
    typedef struct packed {
        logic grf_bad;
        logic addr_bad;
        logic pc_bad;
        logic time_bad;
    } error_t;

endpackage

/* rtl/line_parser.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

module line_parser (
    input  logic                  clk,
    input  logic                  reset,
    input  trace_pkg::char_t      char,
    output trace_pkg::field_op_e  op,
    output logic                  line_done,
    output trace_pkg::format_e    line_format
);

    trace_pkg::parse_state_e state;
    trace_pkg::parse_state_e next_state;
    logic [3:0]              cnt;
    logic [3:0]              next_cnt;
    // set after a star, cleared after a dollar
    logic                    mark;
    logic                    next_mark;

    function automatic logic is_dec(input trace_pkg::char_t c);
        return (c >= "0") && (c <= "9");
    endfunction

    // lower case only
    function automatic logic is_hex(input trace_pkg::char_t c);
        return ((c >= "0") && (c <= "9")) || ((c >= "a") && (c <= "f"));
    endfunction

    always_comb begin
        // anything unexpected drops the line
        next_state = trace_pkg::st_idle;
        next_cnt = cnt;
        next_mark = mark;
        op = trace_pkg::op_none;
        if (char == "^") begin
            next_state = trace_pkg::st_caret;
            next_cnt = 4'd0;
            op = trace_pkg::op_clear;
        end else begin
            case (state)
                trace_pkg::st_caret: begin
                    if (is_dec(char)) begin
                        next_state = trace_pkg::st_time;
                        next_cnt = 4'd1;
                        op = trace_pkg::op_time_digit;
                    end
                end
                trace_pkg::st_time: begin
                    if (is_dec(char) && cnt < `TRACE_DEC_DIGITS) begin
                        next_state = trace_pkg::st_time;
                        next_cnt = cnt + 4'd1;
                        op = trace_pkg::op_time_digit;
                    end else if (char == "@") begin
                        next_state = trace_pkg::st_at;
                    end
                end
                trace_pkg::st_at: begin
                    if (is_hex(char)) begin
                        next_state = trace_pkg::st_pc;
                        next_cnt = 4'd1;
                        op = trace_pkg::op_pc_digit;
                    end
                end
                trace_pkg::st_pc: begin
                    if (is_hex(char) && cnt < `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_pc;
                        next_cnt = cnt + 4'd1;
                        op = trace_pkg::op_pc_digit;
                    end else if (char == ":" && cnt == `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_colon;
                    end
                end
                trace_pkg::st_colon: begin
                    if (char == " ") begin
                        next_state = trace_pkg::st_colon;
                    end else if (char == "$") begin
                        next_state = trace_pkg::st_grf_mark;
                        next_mark = 1'b0;
                    end else if (char == "*") begin
                        next_state = trace_pkg::st_mem_mark;
                        next_mark = 1'b1;
                    end
                end
                trace_pkg::st_grf_mark: begin
                    if (is_dec(char)) begin
                        next_state = trace_pkg::st_grf;
                        next_cnt = 4'd1;
                        op = trace_pkg::op_grf_digit;
                    end
                end
                trace_pkg::st_grf: begin
                    if (is_dec(char) && cnt < `TRACE_DEC_DIGITS) begin
                        next_state = trace_pkg::st_grf;
                        next_cnt = cnt + 4'd1;
                        op = trace_pkg::op_grf_digit;
                    end else if (char == " ") begin
                        next_state = trace_pkg::st_grf_space;
                    end else if (char == "<") begin
                        next_state = trace_pkg::st_lt;
                    end
                end
                trace_pkg::st_grf_space: begin
                    if (char == " ") begin
                        next_state = trace_pkg::st_grf_space;
                    end else if (char == "<") begin
                        next_state = trace_pkg::st_lt;
                    end
                end
                trace_pkg::st_lt: begin
                    if (char == "=") begin
                        next_state = trace_pkg::st_eq;
                    end
                end
                trace_pkg::st_eq: begin
                    if (char == " ") begin
                        next_state = trace_pkg::st_eq;
                    end else if (is_hex(char)) begin
                        next_state = trace_pkg::st_data;
                        next_cnt = 4'd1;
                    end
                end
                // data is checked for syntax only, no opcode
                trace_pkg::st_data: begin
                    if (is_hex(char) && cnt < `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_data;
                        next_cnt = cnt + 4'd1;
                    end else if (char == "#" && cnt == `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_done;
                    end
                end
                trace_pkg::st_mem_mark: begin
                    if (is_hex(char)) begin
                        next_state = trace_pkg::st_addr;
                        next_cnt = 4'd1;
                        op = trace_pkg::op_addr_digit;
                    end
                end
                trace_pkg::st_addr: begin
                    if (is_hex(char) && cnt < `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_addr;
                        next_cnt = cnt + 4'd1;
                        op = trace_pkg::op_addr_digit;
                    end else if (char == " " && cnt == `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_addr_space;
                    end else if (char == "<" && cnt == `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_addr_lt;
                    end
                end
                trace_pkg::st_addr_space: begin
                    if (char == " ") begin
                        next_state = trace_pkg::st_addr_space;
                    end else if (char == "<") begin
                        next_state = trace_pkg::st_addr_lt;
                    end
                end
                trace_pkg::st_addr_lt: begin
                    if (char == "=") begin
                        next_state = trace_pkg::st_addr_eq;
                    end
                end
                trace_pkg::st_addr_eq: begin
                    if (char == " ") begin
                        next_state = trace_pkg::st_addr_eq;
                    end else if (is_hex(char)) begin
                        next_state = trace_pkg::st_addr_data;
                        next_cnt = 4'd1;
                    end
                end
                trace_pkg::st_addr_data: begin
                    if (is_hex(char) && cnt < `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_addr_data;
                        next_cnt = cnt + 4'd1;
                    end else if (char == "#" && cnt == `TRACE_HEX_DIGITS) begin
                        next_state = trace_pkg::st_done;
                    end
                end
                // idle and done wait for a caret
                default: begin
                    next_state = trace_pkg::st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= trace_pkg::st_idle;
            cnt <= 4'd0;
            mark <= 1'b0;
        end else begin
            state <= next_state;
            cnt <= next_cnt;
            mark <= next_mark;
        end
    end

    assign line_done = (state == trace_pkg::st_done);

    always_comb begin
        if (!line_done) begin
            line_format = trace_pkg::fmt_none;
        end else if (mark) begin
            line_format = trace_pkg::fmt_mem_write;
        end else begin
            line_format = trace_pkg::fmt_reg_write;
        end
    end

endmodule

/* rtl/field_store.sv */
`timescale 1ns/10ps

module field_store (
    input  logic                     clk,
    input  logic                     reset,
    input  trace_pkg::char_t         char,
    input  trace_pkg::field_op_e     op,
    output trace_pkg::line_fields_t  fields
);

    // value of the char as a digit
    logic [3:0] digit;

    // class was already checked by the parser, so bit 6 tells a-f from 0-9
    assign digit = char[6] ? (char[3:0] + 4'd9) : char[3:0];

    // times ten plus the new digit
    function automatic logic [15:0] dec_push(
        input logic [15:0] value,
        input logic [3:0]  d
    );
        logic [15:0] times_ten;
        times_ten = (value << 3) + (value << 1);
        return times_ten + {12'd0, d};
    endfunction

    // one nibble in at the bottom
    function automatic logic [31:0] hex_push(
        input logic [31:0] value,
        input logic [3:0]  d
    );
        return {value[27:0], d};
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            fields <= '0;
        end else begin
            case (op)
                trace_pkg::op_clear: begin
                    fields <= '0;
                end
                trace_pkg::op_time_digit: begin
                    fields.time_val <= dec_push(fields.time_val, digit);
                end
                trace_pkg::op_pc_digit: begin
                    fields.pc <= hex_push(fields.pc, digit);
                end
                trace_pkg::op_grf_digit: begin
                    fields.grf <= dec_push(fields.grf, digit);
                end
                trace_pkg::op_addr_digit: begin
                    fields.addr <= hex_push(fields.addr, digit);
                end
                default: begin
                    fields <= fields;
                end
            endcase
        end
    end

endmodule

/* rtl/line_checker.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

module line_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     line_done,
    input  trace_pkg::format_e       line_format,
    input  trace_pkg::line_fields_t  fields,
    input  logic [15:0]              freq,
    output trace_pkg::format_e       format_type,
    output trace_pkg::error_t        error_code
);

    logic [3:0]        low_pos;
    // half of freq minus one
    logic [15:0]       time_mask;
    trace_pkg::error_t err;

    // lowest set bit of freq, freq being a power of two
    always_comb begin
        low_pos = 4'd0;
        for (int i = 15; i >= 0; i--) begin
            if (freq[i]) begin
                low_pos = i[3:0];
            end
        end
    end

    assign time_mask = ((16'd1 << low_pos) >> 1) - 16'd1;

    always_comb begin
        err.time_bad = |(fields.time_val & time_mask);
        err.pc_bad = (fields.pc < `TRACE_PC_MIN) || (fields.pc > `TRACE_PC_MAX)
                     || (fields.pc[1:0] != 2'b00);
        err.addr_bad = (line_format == trace_pkg::fmt_mem_write)
                       && ((fields.addr > `TRACE_ADDR_MAX) || (fields.addr[1:0] != 2'b00));
        err.grf_bad = (line_format == trace_pkg::fmt_reg_write)
                      && (fields.grf > `TRACE_GRF_MAX);
    end

    // one-cycle report, zero otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            format_type <= trace_pkg::fmt_none;
            error_code <= '0;
        end else if (line_done) begin
            format_type <= line_format;
            error_code <= err;
        end else begin
            format_type <= trace_pkg::fmt_none;
            error_code <= '0;
        end
    end

endmodule

/* rtl/trace_checker.sv */
`timescale 1ns/10ps

module trace_checker (
    input  logic                clk,
    input  logic                reset,
    input  trace_pkg::char_t    char,
    input  logic [15:0]         freq,
    output trace_pkg::format_e  format_type,
    output trace_pkg::error_t   error_code
);

    trace_pkg::field_op_e    op;
    logic                    line_done;
    trace_pkg::format_e      line_format;
    trace_pkg::line_fields_t fields;

    // syntax walk, one char per clock
    line_parser parser_i (
        .clk         (clk),
        .reset       (reset),
        .char        (char),
        .op          (op),
        .line_done   (line_done),
        .line_format (line_format)
    );

    // applies the opcode at the same edge
    field_store store_i (
        .clk    (clk),
        .reset  (reset),
        .char   (char),
        .op     (op),
        .fields (fields)
    );

    line_checker checker_i (
        .clk         (clk),
        .reset       (reset),
        .line_done   (line_done),
        .line_format (line_format),
        .fields      (fields),
        .freq        (freq),
        .format_type (format_type),
        .error_code  (error_code)
    );

endmodule

/* sim/trace_checker_asserts.sv */
`timescale 1ns/10ps

module trace_checker_asserts (
    input logic                clk,
    input logic                reset,
    input trace_pkg::format_e  format_type,
    input trace_pkg::error_t   error_code
);

    // a report lasts exactly one cycle
    report_single: assert property (
        @(posedge clk) disable iff (reset)
        (format_type != trace_pkg::fmt_none) |=> (format_type == trace_pkg::fmt_none)
    ) else $error("format_type nonzero on two consecutive cycles");

    report_quiet: assert property (
        @(posedge clk) disable iff (reset)
        (format_type == trace_pkg::fmt_none) |-> (error_code == 4'h0)
    ) else $error("error_code nonzero without a report");

    // grf and addr bits each belong to one format only
    report_bits_match: assert property (
        @(posedge clk) disable iff (reset)
        !((format_type == trace_pkg::fmt_mem_write) && error_code.grf_bad)
        && !((format_type == trace_pkg::fmt_reg_write) && error_code.addr_bad)
    ) else $error("error bit does not belong to the reported format");

endmodule

bind trace_checker trace_checker_asserts asserts_i (
    .clk         (clk),
    .reset       (reset),
    .format_type (format_type),
    .error_code  (error_code)
);

/* sim/trace_checker_tb.sv */
`timescale 1ns/10ps
`include "trace_defines.svh"

module trace_checker_tb;

    typedef struct packed {
        trace_pkg::format_e fmt;
        trace_pkg::error_t  err;
    } report_t;

    logic                   clk = 1'b0;
    logic                   reset;
    trace_pkg::char_t       char;
    logic [15:0]            freq;
    trace_pkg::format_e     format_type;
    trace_pkg::error_t      error_code;

    report_t                exp_q[$];
    logic [31:0]            lfsr = 32'h7454_b72a;
    int                     errors = 0;
    int                     checks = 0;
    int                     cycles = 0;
    int                     chars_sent = 0;

    trace_checker dut_i (
        .clk         (clk),
        .reset       (reset),
        .char        (char),
        .freq        (freq),
        .format_type (format_type),
        .error_code  (error_code)
    );

    always #5 clk = ~clk;

    // taps 32 22 2 1 with one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic string spaces(input int n);
        string s;
        s = "";
        for (int i = 0; i < n; i++) begin
            s = {s, " "};
        end
        return s;
    endfunction

    // reference model straight from the line rules
    function automatic report_t expected_report(input bit mem, input int t,
            input logic [31:0] pc, input int grf, input logic [31:0] addr,
            input logic [15:0] f);
        report_t r;
        r.fmt = mem ? trace_pkg::fmt_mem_write : trace_pkg::fmt_reg_write;
        r.err.time_bad = (t % (int'(f) / 2)) != 0;
        r.err.pc_bad = (pc < `TRACE_PC_MIN) || (pc > `TRACE_PC_MAX) || (pc % 4 != 0);
        r.err.addr_bad = mem && ((addr > `TRACE_ADDR_MAX) || (addr % 4 != 0));
        r.err.grf_bad = !mem && (grf > int'(`TRACE_GRF_MAX));
        return r;
    endfunction

    task automatic send_string(input string s);
        for (int i = 0; i < s.len(); i++) begin
            @(posedge clk);
            char <= s[i];
            chars_sent++;
        end
    endtask

    task automatic idle(input int n);
        send_string(spaces(n));
    endtask

    // waits an extra edge so the model sees the new freq
    task automatic set_freq(input logic [15:0] f);
        @(posedge clk);
        freq <= f;
        @(posedge clk);
    endtask

    task automatic send_line(input string prefix, input bit mem, input int t,
            input logic [31:0] pc, input int grf, input logic [31:0] addr,
            input logic [31:0] data, input int sp);
        string s;
        if (mem) begin
            s = $sformatf("^%0d@%08h:%s*%08h%s<=%s%08h#", t, pc, spaces(sp), addr,
                          spaces(sp), spaces(sp), data);
        end else begin
            s = $sformatf("^%0d@%08h:%s$%0d%s<=%s%08h#", t, pc, spaces(sp), grf,
                          spaces(sp), spaces(sp), data);
        end
        exp_q.push_back(expected_report(mem, t, pc, grf, addr, freq));
        send_string({prefix, s});
    endtask

    task automatic drain_check(input string test_name);
        idle(4);
        checks++;
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%s: %0d expected reports never arrived", test_name, exp_q.size());
        end
        exp_q.delete();
    endtask

    task automatic legal_lines();
        set_freq(16'd4);
        send_line("", 1'b0, 8, 32'h0000_3000, 5, 32'h0, 32'hdead_beef, 1);
        idle(3);
        send_line("", 1'b1, 12, 32'h0000_3004, 0, 32'h0000_0100, 32'h0123_4567, 0);
        drain_check("legal lines");
    endtask

    task automatic bad_fields();
        send_line("", 1'b0, 2, 32'h0000_2ffc, 1, 32'h0, 32'h0, 1);
        send_line("", 1'b0, 2, 32'h0000_3002, 1, 32'h0, 32'h0, 2);
        send_line("", 1'b1, 4, 32'h0000_3000, 0, 32'h0000_3000, 32'h0, 1);
        send_line("", 1'b1, 4, 32'h0000_3000, 0, 32'h0000_0001, 32'h0, 3);
        send_line("", 1'b0, 6, 32'h0000_3000, 32, 32'h0, 32'h0, 1);
        send_line("", 1'b0, 7, 32'h0000_3000, 1, 32'h0, 32'h0, 1);
        drain_check("bad fields");
    endtask

    // none of these may produce a report
    task automatic malformed_lines();
        send_string("^12345@00003000: $1 <= 00000000#  ");
        send_string("^1@0000300: $1 <= 00000000#  ");
        send_string("^1@000030000: $1 <= 00000000#  ");
        send_string("^1@00003000: $1 <= 0000000#  ");
        send_string("^1@00003000: $1 <= 000000000#  ");
        send_string("^1@00003000: $1 < 00000000#  ");
        send_string("^1@0000300A: $1 <= 00000000#  ");
        send_string("^1@00003000: *00000100 <= 1234567#  ");
        drain_check("malformed lines");
    endtask

    // stale grf digits would push the new grf out of range
    task automatic caret_restart();
        send_line("^12@00003000: $7", 1'b0, 8, 32'h0000_3000, 3, 32'h0, 32'h1234_5678, 1);
        idle(2);
        send_line("^4@00003000: *000", 1'b0, 9, 32'h0000_4ffc, 40, 32'h0, 32'h0, 1);
        drain_check("caret restart");
    endtask

    // caret right after the hash
    task automatic back_to_back();
        send_line("", 1'b1, 16, 32'h0000_3008, 0, 32'h0000_2ffc, 32'hffff_ffff, 0);
        send_line("", 1'b0, 3, 32'h0000_5000, 31, 32'h0, 32'h0, 1);
        send_line("", 1'b1, 20, 32'h0000_3010, 0, 32'h0000_2ffe, 32'h0, 1);
        drain_check("back to back");
    endtask

    task automatic random_lines();
        bit          mem;
        int          t;
        int          grf;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] r;
        for (int i = 0; i < 40; i++) begin
            r = random_bits(2);
            set_freq(16'd2 << r[1:0]);
            r = random_bits(1);
            mem = r[0];
            t = int'(random_bits(14) % 10000);
            grf = int'(random_bits(6));
            // window straddles both pc limits
            pc = 32'h0000_2800 + random_bits(14);
            addr = random_bits(14);
            data = random_bits(32);
            r = random_bits(2);
            send_line("", mem, t, pc, grf, addr, data, int'(r % 3));
            idle(3);
        end
        drain_check("random lines");
    endtask

    // report watcher
    always @(posedge clk) begin
        report_t e;
        if (!reset) begin
            if (format_type == trace_pkg::fmt_none) begin
                checks++;
                assert (error_code == 4'h0) else begin
                    errors++;
                    $display("FAILED error_code: got %h expected %h", error_code, 4'h0);
                end
            end else begin
                checks++;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("unexpected report at cycle %0d with no line pending", cycles);
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    checks += 2;
                    assert (format_type == e.fmt) else begin
                        errors++;
                        $display("FAILED format_type: got %h expected %h", format_type, e.fmt);
                    end
                    assert (error_code == e.err) else begin
                        errors++;
                        $display("FAILED error_code: got %h expected %h", error_code, e.err);
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > 2 * chars_sent + 200) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        reset = 1'b1;
        char = " ";
        freq = 16'd4;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        legal_lines();
        bad_fields();
        malformed_lines();
        caret_restart();
        back_to_back();
        random_lines();
        $display("errors %0d checks %0d", errors, checks);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+include
rtl/trace_pkg.sv
rtl/line_parser.sv
rtl/field_store.sv
rtl/line_checker.sv
rtl/trace_checker.sv
sim/trace_checker_asserts.sv
sim/trace_checker_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := trace_checker_tb
FILELIST   := all.f
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert
OBJ_DIR    := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
